// ==== rtl/board_params.svh ====
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// bus geometry.
`define BUS_DATA_W 16
`define BUS_ADDR_W 16
`define REGION_W 4
`define OFFSET_W 12

// address regions. all others are unmapped.
`define REGION_SYSCONF 4'd0
`define REGION_IRQ 4'd1
`define REGION_BUSMON 4'd2
`define NUM_SLAVES 3

// cycles without ack before the decoder answers with err.
`define BUS_TIMEOUT_CYCLES 16

// board identity.
`define BOARD_ID 16'hB0C1
`define REV_MAJOR 8'd1
`define REV_MINOR 8'd3
`define CONFIG_DEFAULT 8'h01

`define NUM_EXT_IRQ 3

`endif

// ==== rtl/wb_bus_pkg.sv ====
`include "board_params.svh"

package wb_bus_pkg;

  // region selects the slave, offset picks a register inside it.
  typedef struct packed {
    logic [`REGION_W-1:0] region;
    logic [`OFFSET_W-1:0] offset;
  } wb_addr_fields_t;

  typedef union packed {
    logic [`BUS_ADDR_W-1:0] word;
    wb_addr_fields_t        fields;
  } wb_addr_u;

  // master to slave.
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    wb_addr_u               adr;
    logic [`BUS_DATA_W-1:0] dat;
  } wb_req_t;

  // slave to master.
  typedef struct packed {
    logic                   ack;
    logic                   err;
    logic [`BUS_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

// ==== rtl/board_ctrl_pkg.sv ====
`include "board_params.svh"

package board_ctrl_pkg;

  // ========================================
  // interrupt sources
  // ========================================
  // msb is the bus timeout, the rest are external lines.
  typedef logic [`NUM_EXT_IRQ:0] irq_vec_t;

  // ========================================
  // system configuration
  // ========================================
  typedef logic [7:0] sys_config_t;

endpackage

// ==== rtl/wbs_decoder.sv ====
`timescale 1ns/10ps
`include "board_params.svh"

module wbs_decoder
  import wb_bus_pkg::*;
(
  input  logic                   gclk40,
  input  logic                   hard_reset,
  input  wb_req_t                req_i,
  output wb_rsp_t                rsp_o,
  output logic [`NUM_SLAVES-1:0] slave_sel_o,
  input  wb_rsp_t                slave_rsp_i [`NUM_SLAVES],
  output logic                   timeout_o
);

  // slave index to region number.
  localparam logic [`REGION_W-1:0] REGION_MAP [`NUM_SLAVES] =
    '{`REGION_SYSCONF, `REGION_IRQ, `REGION_BUSMON};
  localparam int CNT_W = $clog2(`BUS_TIMEOUT_CYCLES);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`BUS_TIMEOUT_CYCLES - 1);

  logic             req_active;
  logic             pending;
  logic             timeout_q;
  logic [CNT_W-1:0] wait_cnt_q;
  wb_rsp_t          slave_rsp;

  assign req_active = req_i.cyc && req_i.stb;

  // ========================================
  // region decode and response mux
  // ========================================
  always_comb begin
    for (int i = 0; i < `NUM_SLAVES; i++) begin
      slave_sel_o[i] = req_active && (req_i.adr.fields.region == REGION_MAP[i]);
    end
  end

  always_comb begin
    slave_rsp = '0;
    for (int i = 0; i < `NUM_SLAVES; i++) begin
      if (slave_sel_o[i]) begin
        slave_rsp = slave_rsp_i[i];
      end
    end
  end

  assign rsp_o = '{ack: slave_rsp.ack, err: slave_rsp.err || timeout_q, dat: slave_rsp.dat};

  // ========================================
  // bus timeout
  // ========================================
  // counts while a request waits without any answer.
  assign pending = req_active && !slave_rsp.ack && !timeout_q;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      wait_cnt_q <= '0;
      timeout_q  <= 1'b0;
    end else begin
      timeout_q <= 1'b0;
      if (!pending) begin
        wait_cnt_q <= '0;
      end else if (wait_cnt_q == LAST_CNT) begin
        wait_cnt_q <= '0;
        timeout_q  <= 1'b1;
      end else begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  assign timeout_o = timeout_q;

  // a slave ack never collides with the timeout.
  a_ack_err_excl: assert property (@(posedge gclk40) disable iff (!hard_reset)
    !(rsp_o.ack && rsp_o.err));

  // the master still holds stb when err arrives.
  a_err_in_stb: assert property (@(posedge gclk40) disable iff (!hard_reset)
    rsp_o.err |-> req_i.stb);

endmodule

// ==== rtl/sys_config.sv ====
`timescale 1ns/10ps
`include "board_params.svh"

module sys_config
  import wb_bus_pkg::*;
  import board_ctrl_pkg::*;
(
  input  logic        gclk40,
  input  logic        hard_reset,
  input  logic        sel_i,
  input  wb_req_t     req_i,
  output wb_rsp_t     rsp_o,
  output sys_config_t sys_config_o
);

  localparam logic [`OFFSET_W-1:0] OFS_BOARD_ID = 'd0;
  localparam logic [`OFFSET_W-1:0] OFS_REVISION = 'd1;
  localparam logic [`OFFSET_W-1:0] OFS_CONFIG   = 'd2;
  localparam logic [`OFFSET_W-1:0] OFS_SCRATCH  = 'd3;

  logic                   access;
  logic                   ack_q;
  logic [`BUS_DATA_W-1:0] rd_data;
  logic [`BUS_DATA_W-1:0] rd_data_q;
  logic [`BUS_DATA_W-1:0] scratch_q;
  sys_config_t            config_q;

  // one access per strobe. ack blocks the second cycle.
  assign access = sel_i && !ack_q;

  always_comb begin
    rd_data = '0;
    case (req_i.adr.fields.offset)
      OFS_BOARD_ID: rd_data = `BOARD_ID;
      OFS_REVISION: rd_data = {`REV_MAJOR, `REV_MINOR};
      OFS_CONFIG:   rd_data[$bits(sys_config_t)-1:0] = config_q;
      OFS_SCRATCH:  rd_data = scratch_q;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q    <= 1'b0;
      config_q <= `CONFIG_DEFAULT;
    end else begin
      ack_q <= access;
      if (access && req_i.we && req_i.adr.fields.offset == OFS_CONFIG) begin
        config_q <= req_i.dat[$bits(sys_config_t)-1:0];
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access) begin
      rd_data_q <= rd_data;
    end
    if (access && req_i.we && req_i.adr.fields.offset == OFS_SCRATCH) begin
      scratch_q <= req_i.dat;
    end
  end

  assign rsp_o        = '{ack: ack_q, err: 1'b0, dat: rd_data_q};
  assign sys_config_o = config_q;

endmodule

// ==== rtl/irq_controller.sv ====
`timescale 1ns/10ps
`include "board_params.svh"

module irq_controller
  import wb_bus_pkg::*;
  import board_ctrl_pkg::*;
(
  input  logic     gclk40,
  input  logic     hard_reset,
  input  logic     sel_i,
  input  wb_req_t  req_i,
  output wb_rsp_t  rsp_o,
  input  irq_vec_t irq_src_i,
  output logic     irq_o
);

  localparam logic [`OFFSET_W-1:0] OFS_PENDING = 'd0;
  localparam logic [`OFFSET_W-1:0] OFS_MASK    = 'd1;

  logic                   access;
  logic                   ack_q;
  logic [`BUS_DATA_W-1:0] rd_data;
  logic [`BUS_DATA_W-1:0] rd_data_q;
  irq_vec_t               src_q;
  irq_vec_t               src_rise;
  irq_vec_t               clear;
  irq_vec_t               pending_q;
  irq_vec_t               mask_q;

  assign access   = sel_i && !ack_q;
  assign src_rise = irq_src_i & ~src_q;

  // write one to clear.
  assign clear = (access && req_i.we && req_i.adr.fields.offset == OFS_PENDING) ?
                 req_i.dat[$bits(irq_vec_t)-1:0] : '0;

  always_comb begin
    rd_data = '0;
    case (req_i.adr.fields.offset)
      OFS_PENDING: rd_data[$bits(irq_vec_t)-1:0] = pending_q;
      OFS_MASK:    rd_data[$bits(irq_vec_t)-1:0] = mask_q;
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q     <= 1'b0;
      src_q     <= '0;
      pending_q <= '0;
      mask_q    <= '0;
      irq_o     <= 1'b0;
    end else begin
      ack_q <= access;
      src_q <= irq_src_i;
      // a new edge beats a clear in the same cycle.
      pending_q <= (pending_q & ~clear) | src_rise;
      if (access && req_i.we && req_i.adr.fields.offset == OFS_MASK) begin
        mask_q <= req_i.dat[$bits(irq_vec_t)-1:0];
      end
      irq_o <= |(pending_q & mask_q);
    end
  end

  always_ff @(posedge gclk40) begin
    if (access) begin
      rd_data_q <= rd_data;
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_data_q};

  // no interrupt without a pending source one cycle earlier.
  a_irq_has_source: assert property (@(posedge gclk40) disable iff (!hard_reset)
    irq_o |-> $past(|pending_q));

endmodule

// ==== rtl/bus_monitor.sv ====
`timescale 1ns/10ps
`include "board_params.svh"

module bus_monitor
  import wb_bus_pkg::*;
(
  input  logic    gclk40,
  input  logic    hard_reset,
  input  logic    sel_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o,
  input  logic    timeout_i
);

  localparam logic [`OFFSET_W-1:0] OFS_ADDR  = 'd0;
  localparam logic [`OFFSET_W-1:0] OFS_WE    = 'd1;
  localparam logic [`OFFSET_W-1:0] OFS_COUNT = 'd2;

  logic                   access;
  logic                   ack_q;
  logic [`BUS_DATA_W-1:0] rd_data;
  logic [`BUS_DATA_W-1:0] rd_data_q;
  logic [`BUS_ADDR_W-1:0] last_addr_q;
  logic                   last_we_q;
  logic [7:0]             to_count_q;

  assign access = sel_i && !ack_q;

  // all registers are read only. writes only get an ack.
  always_comb begin
    rd_data = '0;
    case (req_i.adr.fields.offset)
      OFS_ADDR:  rd_data = last_addr_q;
      OFS_WE:    rd_data[0] = last_we_q;
      OFS_COUNT: rd_data[7:0] = to_count_q;
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q       <= 1'b0;
      last_addr_q <= '0;
      last_we_q   <= 1'b0;
      to_count_q  <= '0;
    end else begin
      ack_q <= access;
      if (timeout_i) begin
        last_addr_q <= req_i.adr.word;
        last_we_q   <= req_i.we;
        // saturates at 255.
        if (to_count_q != 8'hff) begin
          to_count_q <= to_count_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access) begin
      rd_data_q <= rd_data;
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_data_q};

endmodule

// ==== rtl/board_ctrl_top.sv ====
`timescale 1ns/10ps
`include "board_params.svh"

module board_ctrl_top
  import wb_bus_pkg::*;
  import board_ctrl_pkg::*;
(
  input  logic                    gclk40,
  input  logic                    hard_reset,
  input  wb_req_t                 req_i,
  output wb_rsp_t                 rsp_o,
  input  logic [`NUM_EXT_IRQ-1:0] ext_irq_i,
  output logic                    irq_o,
  output sys_config_t             sys_config_o
);

  // slave order matches the decoder region map.
  logic [`NUM_SLAVES-1:0] slave_sel;
  wb_rsp_t                slave_rsp [`NUM_SLAVES];
  logic                   bus_timeout;
  irq_vec_t               irq_src;

  assign irq_src = {bus_timeout, ext_irq_i};

  wbs_decoder wbs_decoder_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .req_i(req_i), .rsp_o(rsp_o),
    .slave_sel_o(slave_sel), .slave_rsp_i(slave_rsp),
    .timeout_o(bus_timeout)
  );

  sys_config sys_config_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .sel_i(slave_sel[0]), .req_i(req_i), .rsp_o(slave_rsp[0]),
    .sys_config_o(sys_config_o)
  );

  irq_controller irq_controller_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .sel_i(slave_sel[1]), .req_i(req_i), .rsp_o(slave_rsp[1]),
    .irq_src_i(irq_src), .irq_o(irq_o)
  );

  bus_monitor bus_monitor_inst (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .sel_i(slave_sel[2]), .req_i(req_i), .rsp_o(slave_rsp[2]),
    .timeout_i(bus_timeout)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic gclk40_o,
  output logic hard_reset_o
);

  // 40 ns period.
  initial begin
    gclk40_o = 1'b0;
    forever #20 gclk40_o = ~gclk40_o;
  end

  // reset held low over the first 16 rising edges.
  initial begin
    hard_reset_o = 1'b0;
    repeat (16) @(posedge gclk40_o);
    hard_reset_o <= 1'b1;
  end

endmodule

// ==== testbench/tb_board_ctrl.sv ====
`timescale 1ns/10ps
`include "board_params.svh"

module tb_board_ctrl
  import wb_bus_pkg::*;
  import board_ctrl_pkg::*;
();

  localparam logic [3:0] OP_WRITE = 4'h0;
  localparam logic [3:0] OP_READ  = 4'h1;
  localparam logic [3:0] OP_IRQ   = 4'h2;
  localparam logic [15:0] CONFIG_ADDR = {`REGION_SYSCONF, 12'd2};

  typedef struct packed {
    logic [3:0]  op;
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] exp_data;
    logic        exp_err;
    logic        exp_irq;
  } step_t;

  logic                    gclk40;
  logic                    hard_reset;
  wb_req_t                 req;
  wb_rsp_t                 rsp;
  logic [`NUM_EXT_IRQ-1:0] ext_irq;
  logic                    irq;
  sys_config_t             sys_config;

  step_t       steps[$];
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  sys_config_t exp_config;

  tb_clock_gen clock_gen (.gclk40_o(gclk40), .hard_reset_o(hard_reset));

  board_ctrl_top uut (
    .gclk40(gclk40), .hard_reset(hard_reset),
    .req_i(req), .rsp_o(rsp),
    .ext_irq_i(ext_irq), .irq_o(irq),
    .sys_config_o(sys_config)
  );

  // ========================================
  // helpers
  // ========================================
  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [3:0]  op;
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] exp_data;
    logic [3:0]  exp_err;
    logic [3:0]  exp_irq;
    step_t       s;
    fd = $fopen("testbench/board_ctrl_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/board_ctrl_tests.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %h %h %h %h %h", op, addr, data, exp_data, exp_err, exp_irq);
      if (n == 6) begin
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.exp_data = exp_data;
        s.exp_err  = exp_err[0];
        s.exp_irq  = exp_irq[0];
        steps.push_back(s);
      end else if (n > 0) begin
        $display("malformed line in test file: %s", line);
        error_count++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("ERROR %0t ns %s: got %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  // one request held until ack or err.
  task automatic bus_access(input logic we, input logic [15:0] addr,
                            input logic [15:0] data, output logic [15:0] rdata,
                            output logic err);
    @(posedge gclk40);
    req <= {1'b1, 1'b1, we, addr, data};
    do begin
      @(negedge gclk40);
    end while (!rsp.ack && !rsp.err);
    rdata = rsp.dat;
    err   = rsp.err;
    @(posedge gclk40);
    req <= '0;
  endtask

  task automatic irq_pulse(input logic [`NUM_EXT_IRQ-1:0] lines);
    @(posedge gclk40);
    ext_irq <= lines;
    @(posedge gclk40);
    ext_irq <= '0;
  endtask

  task automatic run_step(input step_t s);
    logic [15:0] rdata;
    logic        err;
    int          gap;
    rdata = '0;
    err   = 1'b0;
    case (s.op)
      OP_WRITE, OP_READ: begin
        bus_access(s.op == OP_WRITE, s.addr, s.data, rdata, err);
        check_value("rsp_o.err", 16'(err), 16'(s.exp_err));
        if (s.op == OP_READ && !s.exp_err) begin
          check_value("rsp_o.dat", rdata, s.exp_data);
        end
        if (s.op == OP_WRITE && !s.exp_err && s.addr == CONFIG_ADDR) begin
          exp_config = s.data[7:0];
        end
      end
      OP_IRQ: irq_pulse(s.data[`NUM_EXT_IRQ-1:0]);
      default: begin
        $display("unknown operation %0h in test step", s.op);
        error_count++;
      end
    endcase
    // irq_o lags pending and mask by a register.
    repeat (2) @(posedge gclk40);
    @(negedge gclk40);
    check_value("irq_o", 16'(irq), 16'(s.exp_irq));
    check_value("sys_config_o", 16'(sys_config), 16'(exp_config));
    gap = 1 + int'($urandom % 4);
    repeat (gap) @(posedge gclk40);
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    req        = '0;
    ext_irq    = '0;
    exp_config = `CONFIG_DEFAULT;
    void'($urandom(6142));
    load_tests();
    cycle_limit = 16 + 40 * steps.size();
    if (steps.size() == 0) begin
      $display("no test steps were loaded");
      error_count++;
    end else begin
      while (!hard_reset) @(posedge gclk40);
      @(negedge gclk40);
      check_value("rsp_o.ack", 16'(rsp.ack), 16'h0);
      check_value("rsp_o.err", 16'(rsp.err), 16'h0);
      check_value("irq_o", 16'(irq), 16'h0);
      check_value("sys_config_o", 16'(sys_config), 16'(exp_config));
      foreach (steps[i]) begin
        run_step(steps[i]);
      end
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog.
  always @(posedge gclk40) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: test steps still running after %0d cycles", cycle_count);
      $display("checks: %0d, errors: %0d", check_count, error_count + 1);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

// ==== testbench/board_ctrl_tests.txt ====
# op addr data expected_data expected_err expected_irq, all hex
# op 0 write, 1 read, 2 irq pulse with data as the external source mask
1 0000 0000 b0c1 0 0
1 0001 0000 0103 0 0
0 0000 ffff 0000 0 0
0 0001 1234 0000 0 0
1 0000 0000 b0c1 0 0
1 0001 0000 0103 0 0
1 0002 0000 0001 0 0
0 0002 00a5 0000 0 0
1 0002 0000 00a5 0 0
0 0003 5a3c 0000 0 0
1 0003 0000 5a3c 0 0
1 2002 0000 0000 0 0
1 7abc 0000 0000 1 0
1 2000 0000 7abc 0 0
1 2001 0000 0000 0 0
1 2002 0000 0001 0 0
0 7010 beef 0000 1 0
1 2000 0000 7010 0 0
1 2001 0000 0001 0 0
1 2002 0000 0002 0 0
0 1000 000f 0000 0 0
2 0000 0002 0000 0 0
1 1000 0000 0002 0 0
0 1001 0002 0000 0 1
0 1000 0002 0000 0 0
0 1001 0008 0000 0 0
1 3000 0000 0000 1 1
1 1000 0000 0008 0 1
0 1000 0008 0000 0 0
1 2002 0000 0003 0 0

// ==== tb.f ====
+incdir+rtl
rtl/wb_bus_pkg.sv
rtl/board_ctrl_pkg.sv
rtl/wbs_decoder.sv
rtl/sys_config.sv
rtl/irq_controller.sv
rtl/bus_monitor.sv
rtl/board_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/tb_board_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_board_ctrl \
  -Mdir obj_dir > compile.log 2>&1
if [ $? -ne 0 ]; then
  cat compile.log
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_board_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
exit 1
